// File: iagc_pkg.sv
`default_nettype none

package iagc_pkg;

  localparam int IAGC_STATUS_SIZE = 4;

  // ----------------------------------------------------------
  // controller status codes
  // ----------------------------------------------------------
  // the values are the fixed codes seen by the LED decode and on o_status
  typedef enum logic [IAGC_STATUS_SIZE-1:0] {
    IAGC_STATUS_RESET     = 4'd0,
    IAGC_STATUS_INIT      = 4'd1,
    IAGC_STATUS_IDLE      = 4'd2,
    IAGC_STATUS_SAMPLE    = 4'd3,
    IAGC_STATUS_CMD_ERROR = 4'd6,
    IAGC_STATUS_DUMP_REF  = 4'd7,
    IAGC_STATUS_DUMP_ERR  = 4'd8,
    IAGC_STATUS_HALT      = 4'd12
  } iagc_status_e;

  typedef logic [IAGC_STATUS_SIZE-1:0] iagc_cmd_t;

  // valid opcodes share the code of the state they start
  localparam iagc_cmd_t CMD_SAMPLE   = iagc_cmd_t'(IAGC_STATUS_SAMPLE);
  localparam iagc_cmd_t CMD_DUMP_REF = iagc_cmd_t'(IAGC_STATUS_DUMP_REF);
  localparam iagc_cmd_t CMD_DUMP_ERR = iagc_cmd_t'(IAGC_STATUS_DUMP_ERR);
  localparam iagc_cmd_t CMD_HALT     = iagc_cmd_t'(IAGC_STATUS_HALT);

  // ----------------------------------------------------------
  // data widths
  // ----------------------------------------------------------
  typedef logic signed [11:0] sample_t;
  typedef logic signed [15:0] corr_acc_t;  // 8 full-scale samples fit with room to spare

  // ----------------------------------------------------------
  // timing
  // ----------------------------------------------------------
  localparam int INIT_CYCLES   = 16;
  localparam int DUMP_CYCLES   = 8;
  localparam int SAMPLE_COUNT  = 8;  // valid samples per correlation window
  localparam int LED_PWM_TICKS = 50;  // strobe fires once every LED_PWM_TICKS + 1 cycles

endpackage

`default_nettype wire

// File: window_if.sv
`timescale 1ns/10ps
`default_nettype none

// one correlation window between the sequencer and the phase detector
interface window_if;

  logic start;     // one-cycle pulse in the first SAMPLE cycle
  logic busy;      // high while the window collects samples
  logic done;      // one-cycle pulse after the last sample
  logic in_phase;  // result of the last finished window

  modport seq (
    output start,
    input  busy,
    input  done,
    input  in_phase
  );

  modport det (
    input  start,
    output busy,
    output done,
    output in_phase
  );

endinterface

`default_nettype wire

// File: iagc_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module iagc_sequencer
  import iagc_pkg::*;
(
  input  wire            i_clock,
  input  wire            i_rst,
  input  wire            i_cmd_valid,
  input  wire iagc_cmd_t i_cmd,
  output iagc_status_e   o_status,
  window_if.seq          win
);

  localparam int CNT_W = $clog2(INIT_CYCLES);

  iagc_status_e     state;
  iagc_status_e     state_next;
  logic [CNT_W-1:0] cycle_cnt;  // shared by INIT and the dump states
  logic             start_q;

  // unknown opcodes all end up in the error state
  function automatic iagc_status_e decode_cmd(input iagc_cmd_t cmd);
    case (cmd)
      CMD_SAMPLE:   decode_cmd = IAGC_STATUS_SAMPLE;
      CMD_DUMP_REF: decode_cmd = IAGC_STATUS_DUMP_REF;
      CMD_DUMP_ERR: decode_cmd = IAGC_STATUS_DUMP_ERR;
      CMD_HALT:     decode_cmd = IAGC_STATUS_HALT;
      default:      decode_cmd = IAGC_STATUS_CMD_ERROR;
    endcase
  endfunction

  // ----------------------------------------------------------
  // next state
  // ----------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      IAGC_STATUS_RESET: begin
        state_next = IAGC_STATUS_INIT;
      end
      IAGC_STATUS_INIT: begin
        if (cycle_cnt == CNT_W'(INIT_CYCLES - 1)) begin
          state_next = IAGC_STATUS_IDLE;
        end
      end
      IAGC_STATUS_IDLE: begin
        if (i_cmd_valid) begin  // commands are only looked at here
          state_next = decode_cmd(i_cmd);
        end
      end
      IAGC_STATUS_SAMPLE: begin
        if (win.done) begin
          state_next = IAGC_STATUS_IDLE;
        end
      end
      IAGC_STATUS_DUMP_REF, IAGC_STATUS_DUMP_ERR: begin
        if (cycle_cnt == CNT_W'(DUMP_CYCLES - 1)) begin
          state_next = IAGC_STATUS_IDLE;
        end
      end
      IAGC_STATUS_CMD_ERROR: begin
        state_next = IAGC_STATUS_IDLE;
      end
      IAGC_STATUS_HALT: begin
        state_next = IAGC_STATUS_HALT;  // only reset gets out of here
      end
      default: begin
        state_next = IAGC_STATUS_IDLE;
      end
    endcase
  end

  // ----------------------------------------------------------
  // state, duration counter and window start
  // ----------------------------------------------------------
  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      state     <= IAGC_STATUS_RESET;
      cycle_cnt <= '0;
      start_q   <= 1'b0;
    end else begin
      state   <= state_next;
      start_q <= (state_next == IAGC_STATUS_SAMPLE) && (state != IAGC_STATUS_SAMPLE);
      if (state_next != state) begin
        cycle_cnt <= '0;  // every state starts counting from zero
      end else begin
        cycle_cnt <= cycle_cnt + 1'b1;
      end
    end
  end

  assign o_status  = state;
  assign win.start = start_q;

  // a window is only started in the first SAMPLE cycle after IDLE
  assert property (@(posedge i_clock) disable iff (i_rst)
    win.start |-> (state == IAGC_STATUS_SAMPLE) && ($past(state) == IAGC_STATUS_IDLE));

  assert property (@(posedge i_clock) disable iff (i_rst)
    (state == IAGC_STATUS_HALT) |=> (state == IAGC_STATUS_HALT));

endmodule

`default_nettype wire

// File: phase_detector.sv
`timescale 1ns/10ps
`default_nettype none

module phase_detector
  import iagc_pkg::*;
(
  input  wire          i_clock,
  input  wire          i_rst,
  input  wire          i_sample_valid,
  input  wire sample_t i_sample,
  input  wire          i_ref_sign,
  window_if.det        win
);

  localparam int CNT_W = $clog2(SAMPLE_COUNT);

  corr_acc_t        acc;
  corr_acc_t        term;
  corr_acc_t        acc_next;
  logic [CNT_W-1:0] sample_cnt;
  logic             busy_q;
  logic             done_q;
  logic             in_phase_q;
  logic             take;

  assign take = busy_q && i_sample_valid;  // samples outside a window are dropped

  // sign-extend first so that negating the most negative sample cannot wrap
  always_comb begin
    term = corr_acc_t'(i_sample);
    if (i_ref_sign) begin
      term = -term;
    end
    acc_next = acc + term;
  end

  // ----------------------------------------------------------
  // window control
  // ----------------------------------------------------------
  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      in_phase_q <= 1'b0;
      sample_cnt <= '0;
    end else begin
      done_q <= 1'b0;
      if (win.start) begin
        busy_q     <= 1'b1;
        sample_cnt <= '0;
      end else if (take) begin
        sample_cnt <= sample_cnt + 1'b1;
        if (sample_cnt == CNT_W'(SAMPLE_COUNT - 1)) begin
          busy_q     <= 1'b0;
          done_q     <= 1'b1;
          in_phase_q <= ~acc_next[$bits(corr_acc_t)-1];  // zero counts as in phase
        end
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (win.start) begin
      acc <= '0;
    end else if (take) begin
      acc <= acc_next;
    end
  end

  assign win.busy     = busy_q;
  assign win.done     = done_q;
  assign win.in_phase = in_phase_q;

  // done closes a window that was open on the cycle before
  assert property (@(posedge i_clock) disable iff (i_rst)
    win.done |-> $past(win.busy) && !win.busy);

endmodule

`default_nettype wire

// File: pmod_unit.sv
`timescale 1ns/10ps
`default_nettype none

module pmod_unit
  import iagc_pkg::*;
(
  input  wire               i_clock,
  input  wire               i_rst,
  input  wire iagc_status_e i_status,
  input  wire               i_in_phase,
  output logic              o_led0_r,
  output logic              o_led0_g,
  output logic              o_led0_b,
  output logic              o_led1_r,
  output logic              o_led1_g,
  output logic              o_led1_b
);

  localparam int PWM_W = $clog2(LED_PWM_TICKS + 1);

  logic [PWM_W-1:0] pwm_cnt;
  logic             led_pwm;  // one cycle high per PWM period

  // ----------------------------------------------------------
  // PWM strobe
  // ----------------------------------------------------------
  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      pwm_cnt <= '0;
      led_pwm <= 1'b0;
    end else if (pwm_cnt == PWM_W'(LED_PWM_TICKS)) begin
      pwm_cnt <= '0;
      led_pwm <= 1'b1;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
      led_pwm <= 1'b0;
    end
  end

  // ----------------------------------------------------------
  // colour decode
  // ----------------------------------------------------------
  always_comb begin
    o_led0_r = 1'b0;
    o_led0_g = 1'b0;
    o_led0_b = 1'b0;
    case (i_status)
      IAGC_STATUS_INIT:   o_led0_r = led_pwm;
      IAGC_STATUS_IDLE:   o_led0_g = led_pwm;
      IAGC_STATUS_SAMPLE: o_led0_b = led_pwm;
      IAGC_STATUS_DUMP_REF, IAGC_STATUS_DUMP_ERR: begin
        o_led0_r = led_pwm;  // yellow for both dumps
        o_led0_g = led_pwm;
      end
      default: begin
        o_led0_r = 1'b0;
      end
    endcase

    // green when in phase, red when not
    o_led1_r = led_pwm & ~i_in_phase;
    o_led1_g = led_pwm & i_in_phase;
    o_led1_b = 1'b0;
  end

  assert property (@(posedge i_clock) disable iff (i_rst)
    !(o_led0_b && o_led0_r));

endmodule

`default_nettype wire

// File: iagc_monitor_top.sv
`timescale 1ns/10ps
`default_nettype none

module iagc_monitor_top
  import iagc_pkg::*;
(
  input  wire                          i_clock,
  input  wire                          i_rst,
  input  wire                          i_cmd_valid,
  input  wire [$bits(iagc_cmd_t)-1:0]  i_cmd,
  input  wire                          i_sample_valid,
  input  wire [$bits(sample_t)-1:0]    i_sample,
  input  wire                          i_ref_sign,
  output wire [IAGC_STATUS_SIZE-1:0]   o_status,
  output wire                          o_in_phase,
  output wire                          o_led0_r,
  output wire                          o_led0_g,
  output wire                          o_led0_b,
  output wire                          o_led1_r,
  output wire                          o_led1_g,
  output wire                          o_led1_b
);

  iagc_status_e status;

  window_if win ();

  iagc_sequencer u_sequencer (
    .i_clock     (i_clock),
    .i_rst       (i_rst),
    .i_cmd_valid (i_cmd_valid),
    .i_cmd       (i_cmd),
    .o_status    (status),
    .win         (win.seq)
  );

  phase_detector u_phase_detector (
    .i_clock        (i_clock),
    .i_rst          (i_rst),
    .i_sample_valid (i_sample_valid),
    .i_sample       (i_sample),
    .i_ref_sign     (i_ref_sign),
    .win            (win.det)
  );

  // LED0 follows the controller state and LED1 the last window result
  pmod_unit u_pmod_unit (
    .i_clock    (i_clock),
    .i_rst      (i_rst),
    .i_status   (status),
    .i_in_phase (win.in_phase),
    .o_led0_r   (o_led0_r),
    .o_led0_g   (o_led0_g),
    .o_led0_b   (o_led0_b),
    .o_led1_r   (o_led1_r),
    .o_led1_g   (o_led1_g),
    .o_led1_b   (o_led1_b)
  );

  assign o_status   = status;
  assign o_in_phase = win.in_phase;

endmodule

`default_nettype wire

// File: tb_iagc_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module tb_iagc_monitor
  import iagc_pkg::*;
();

  localparam int CLK_PERIOD  = 100;
  localparam int TEST_CYCLES = 30 + 40 + 200 + 520 + 150;  // upper length of each test in turn

  logic         i_clock;
  logic         i_rst;
  logic         i_cmd_valid;
  iagc_cmd_t    i_cmd;
  logic         i_sample_valid;
  sample_t      i_sample;
  logic         i_ref_sign;
  wire [3:0]    o_status;
  wire          o_in_phase;
  wire          o_led0_r, o_led0_g, o_led0_b, o_led1_r, o_led1_g, o_led1_b;
  wire [5:0]    leds = {o_led0_r, o_led0_g, o_led0_b, o_led1_r, o_led1_g, o_led1_b};

  iagc_status_e m_status;
  iagc_status_e m_next;
  int           m_left, m_count, m_acc, m_since;
  logic         m_start, m_busy, m_done, m_done_seen, m_in_phase, m_strobe, m_valid;
  integer       seed;
  int           errors, checks, tests, mark;

  iagc_monitor_top UUT (.*);

  always #(CLK_PERIOD / 2) i_clock = ~i_clock;

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  function automatic iagc_status_e next_status(input iagc_status_e st, input int left,
                                               input logic valid, input iagc_cmd_t cmd,
                                               input logic done);
    case (st)
      IAGC_STATUS_RESET:     return IAGC_STATUS_INIT;
      IAGC_STATUS_SAMPLE:    return done ? IAGC_STATUS_IDLE : st;
      IAGC_STATUS_CMD_ERROR: return IAGC_STATUS_IDLE;
      IAGC_STATUS_HALT:      return st;
      IAGC_STATUS_IDLE: begin
        if (!valid) return st;
        if (cmd == CMD_SAMPLE || cmd == CMD_DUMP_REF || cmd == CMD_DUMP_ERR || cmd == CMD_HALT)
          return iagc_status_e'(cmd);  // valid opcodes carry the code of their state
        return IAGC_STATUS_CMD_ERROR;
      end
      default:               return (left == 1) ? IAGC_STATUS_IDLE : st;  // INIT and dumps
    endcase
  endfunction

  function automatic logic [5:0] expected_leds(input iagc_status_e st, input logic ph,
                                               input logic strobe);
    logic [2:0] led0;
    case (st)
      IAGC_STATUS_INIT:                           led0 = 3'b100;
      IAGC_STATUS_IDLE:                           led0 = 3'b010;
      IAGC_STATUS_SAMPLE:                         led0 = 3'b001;
      IAGC_STATUS_DUMP_REF, IAGC_STATUS_DUMP_ERR: led0 = 3'b110;
      default:                                    led0 = 3'b000;
    endcase
    return {led0, !ph, ph, 1'b0} & {6{strobe}};
  endfunction

  always @(posedge i_clock) begin
    m_valid = 1'b1;
    if (i_rst) begin
      m_status   = IAGC_STATUS_RESET;
      m_start    = 1'b0;
      m_busy     = 1'b0;
      m_done     = 1'b0;
      m_in_phase = 1'b0;
      m_since    = 0;
    end else begin
      m_done_seen = m_done;
      m_done      = 1'b0;
      if (m_start) begin
        m_busy  = 1'b1;
        m_count = 0;
        m_acc   = 0;
      end else if (m_busy && i_sample_valid) begin
        m_acc   = i_ref_sign ? m_acc - int'(i_sample) : m_acc + int'(i_sample);
        m_count = m_count + 1;
        if (m_count == SAMPLE_COUNT) begin
          m_busy     = 1'b0;
          m_done     = 1'b1;
          m_in_phase = (m_acc >= 0);
        end
      end
      m_next   = next_status(m_status, m_left, i_cmd_valid, i_cmd, m_done_seen);
      m_start  = (m_next == IAGC_STATUS_SAMPLE) && (m_status != IAGC_STATUS_SAMPLE);
      m_left   = (m_next == m_status) ? m_left - 1 :
                 (m_next == IAGC_STATUS_INIT) ? INIT_CYCLES : DUMP_CYCLES;
      m_status = m_next;
      m_since  = m_since + 1;
    end
    m_strobe = (m_since > 0) && (m_since % (LED_PWM_TICKS + 1) == 0);  // first pulse at 51
  end

  // outputs are settled half a cycle after the edge
  always @(negedge i_clock) begin
    if (m_valid) begin
      checks = checks + 1;
      assert (o_status === m_status && o_in_phase === m_in_phase) else begin
        errors = errors + 1;
        $display("Mismatch at %0t ns: status %0d phase %b, expected %0d phase %b", $time,
                 o_status, o_in_phase, m_status, m_in_phase);
      end
      assert (leds === expected_leds(m_status, m_in_phase, m_strobe)) else begin
        errors = errors + 1;
        $display("Mismatch at %0t ns: LEDs %b, expected %b", $time, leds,
                 expected_leds(m_status, m_in_phase, m_strobe));
      end
    end
  end

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------
  task automatic next_cycle();
    @(posedge i_clock);
    #10;
  endtask

  task automatic apply_reset();
    i_rst = 1'b1;
    repeat (2) next_cycle();
    i_rst = 1'b0;
  endtask

  task automatic send_cmd(input iagc_cmd_t cmd);
    i_cmd_valid = 1'b1;
    i_cmd       = cmd;
    next_cycle();
    i_cmd_valid = 1'b0;
  endtask

  task automatic wait_status(input iagc_status_e st, input int limit);
    int k;
    k = 0;
    while (o_status !== st && k < limit) begin
      next_cycle();
      k = k + 1;
    end
    assert (o_status === st) else begin
      errors = errors + 1;
      $display("status did not reach %0d within %0d cycles", st, limit);
    end
  endtask

  // random samples and signs with gaps until the window closes
  task automatic feed_window();
    int k;
    k = 0;
    while (o_status === IAGC_STATUS_SAMPLE && k < 100) begin
      i_sample_valid = ($random(seed) & 3) != 0;  // about one gap in four
      i_sample       = sample_t'($random(seed));
      i_ref_sign     = 1'($random(seed));
      next_cycle();
      k = k + 1;
    end
    i_sample_valid = 1'b0;
    wait_status(IAGC_STATUS_IDLE, 0);
  endtask

  task automatic end_test(input string name);
    tests = tests + 1;
    $display("test %0d %s: %0d errors", tests, name, errors - mark);
    mark = errors;
  endtask

  initial begin
    i_clock        = 1'b0;
    i_rst          = 1'b1;
    i_cmd_valid    = 1'b0;
    i_cmd          = '0;
    i_sample_valid = 1'b0;
    i_sample       = '0;
    i_ref_sign     = 1'b0;
    seed           = 32'h5906_28c9;
    m_valid        = 1'b0;
    errors         = 0;
    checks         = 0;
    tests          = 0;
    mark           = 0;

    apply_reset();
    wait_status(IAGC_STATUS_IDLE, INIT_CYCLES + 1);  // one RESET cycle, then INIT
    end_test("startup");

    send_cmd(CMD_DUMP_REF);
    wait_status(IAGC_STATUS_IDLE, DUMP_CYCLES);
    send_cmd(CMD_DUMP_ERR);
    send_cmd(CMD_HALT);  // arrives while dumping, so it must be dropped
    wait_status(IAGC_STATUS_IDLE, DUMP_CYCLES);
    send_cmd(iagc_cmd_t'(5));
    wait_status(IAGC_STATUS_IDLE, 1);
    end_test("commands");

    repeat (8) begin
      send_cmd(CMD_SAMPLE);
      feed_window();
    end
    end_test("sample windows");

    // three strobe periods each in IDLE, in an open window and across dumps
    repeat (3 * (LED_PWM_TICKS + 1)) next_cycle();
    send_cmd(CMD_SAMPLE);
    repeat (3 * (LED_PWM_TICKS + 1)) next_cycle();
    feed_window();
    repeat (10) begin
      send_cmd(CMD_DUMP_REF);
      wait_status(IAGC_STATUS_IDLE, DUMP_CYCLES);
      send_cmd(CMD_DUMP_ERR);
      wait_status(IAGC_STATUS_IDLE, DUMP_CYCLES);
    end
    end_test("led decode");

    send_cmd(CMD_HALT);
    repeat (120) begin
      i_cmd_valid    = 1'($random(seed));
      i_cmd          = iagc_cmd_t'($random(seed));
      i_sample_valid = 1'($random(seed));
      i_sample       = sample_t'($random(seed));
      next_cycle();
      assert (o_status === IAGC_STATUS_HALT && leds[5:3] === 3'b000) else begin
        errors = errors + 1;
        $display("Mismatch at %0t ns: status %0d LED0 %b while halted", $time,
                 o_status, leds[5:3]);
      end
    end
    i_cmd_valid    = 1'b0;
    i_sample_valid = 1'b0;
    apply_reset();
    wait_status(IAGC_STATUS_IDLE, INIT_CYCLES + 1);
    end_test("halt");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(TEST_CYCLES * 2 * CLK_PERIOD);
    $display("watchdog expired at %0t ns before the tests finished", $time);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
iagc_pkg.sv
window_if.sv
iagc_sequencer.sv
phase_detector.sv
pmod_unit.sv
iagc_monitor_top.sv
tb_iagc_monitor.sv
